// File: common/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// core-side address and data widths
`define ADDR_W 32
`define DATA_W 32

// AXI master data bus, two 32-bit lanes
`define AXI_DATA_W 64

// mtime word addresses, low word then high word
`define RTC_ADDR    32'ha000_0048
`define RTC_ADDR_HI 32'ha000_004c

// byte strobes on the AXI side
`define AXI_STRB_W (`AXI_DATA_W / 8)

`endif

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // access width as the requester sees it
  typedef enum logic [1:0]
  {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } access_size_t;

  // where a request ends up
  typedef enum logic
  {
    ROUTE_AXI,
    ROUTE_CLINT
  } route_t;

  // strobe 1, 3 or f; anything else is treated as a word
  function automatic access_size_t size_from_strb(input logic [3:0] strb);
    case (strb)
      4'h1:    return SIZE_BYTE;
      4'h3:    return SIZE_HALF;
      default: return SIZE_WORD;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: common/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // AxSIZE, bytes per beat as log2
  typedef enum logic [2:0]
  {
    AXI_SIZE_1B = 3'd0,
    AXI_SIZE_2B = 3'd1,
    AXI_SIZE_4B = 3'd2
  } axi_size_t;

  // xRESP codes
  typedef enum logic [1:0]
  {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

`default_nettype wire

// File: common/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

interface mem_req_if;

  // request side, level held until done
  logic                valid;
  logic                write;
  logic [`ADDR_W-1:0]  addr;
  logic [`DATA_W-1:0]  wdata;
  logic [3:0]          strb;

  // response side, rdata and err qualified by done
  logic [`DATA_W-1:0]  rdata;
  logic                done;
  logic                err;

  modport requester (
    output valid, write, addr, wdata, strb,
    input  rdata, done, err
  );

  modport target (
    input  valid, write, addr, wdata, strb,
    output rdata, done, err
  );

endinterface

`default_nettype wire

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_arbiter import bus_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // instruction fetch
  input  logic [`ADDR_W-1:0] ifu_araddr_i,
  input  logic               ifu_arvalid_i,
  output logic [`DATA_W-1:0] ifu_rdata_o,
  output logic               ifu_rvalid_o,
  // lsu load
  input  logic [`ADDR_W-1:0] lsu_araddr_i,
  input  logic               lsu_arvalid_i,
  input  logic [3:0]         lsu_rstrb_i,
  output logic [`DATA_W-1:0] lsu_rdata_o,
  output logic               lsu_rvalid_o,
  // lsu store
  input  logic [`ADDR_W-1:0] lsu_awaddr_i,
  input  logic [`DATA_W-1:0] lsu_wdata_i,
  input  logic [3:0]         lsu_wstrb_i,
  input  logic               lsu_wvalid_i,
  output logic               lsu_wready_o,
  output logic               bus_error_o,
  mem_req_if.requester       axi_req,
  mem_req_if.requester       clint_req
);

  // who holds the AXI bridge
  typedef enum logic [1:0]
  {
    OWN_NONE,
    OWN_IFU,
    OWN_LOAD,
    OWN_STORE
  } owner_t;

  owner_t owner_q;
  owner_t sel;
  route_t load_route;

  // only loads can hit mtime, fetches and stores always go to AXI
  assign load_route = ((lsu_araddr_i == `RTC_ADDR) || (lsu_araddr_i == `RTC_ADDR_HI)) ?
                      ROUTE_CLINT : ROUTE_AXI;

  // fresh pick only when idle, otherwise the locked owner
  always_comb
  begin
    sel = owner_q;
    if (owner_q == OWN_NONE)
    begin
      if (lsu_wvalid_i)
        sel = OWN_STORE;
      else if (lsu_arvalid_i && (load_route == ROUTE_AXI))
        sel = OWN_LOAD;
      // a pending load of either route keeps the fetch out
      else if (ifu_arvalid_i && !lsu_arvalid_i)
        sel = OWN_IFU;
    end
  end

  // grant locks in the request cycle, frees on done
  always_ff @(posedge clk)
  begin
    if (rst)
      owner_q <= OWN_NONE;
    else
      owner_q <= axi_req.done ? OWN_NONE : sel;
  end

  // steer the granted request into the bridge
  assign axi_req.valid = (sel != OWN_NONE);
  assign axi_req.write = (sel == OWN_STORE);
  assign axi_req.wdata = lsu_wdata_i;
  assign axi_req.addr  = (sel == OWN_STORE) ? lsu_awaddr_i :
                         (sel == OWN_LOAD)  ? lsu_araddr_i : ifu_araddr_i;
  assign axi_req.strb  = (sel == OWN_STORE) ? lsu_wstrb_i :
                         (sel == OWN_LOAD)  ? lsu_rstrb_i : 4'hf;

  // mtime reads stay off while a fetch holds the bridge
  // so the two read pulses never coincide
  assign clint_req.valid = lsu_arvalid_i && (load_route == ROUTE_CLINT) && (sel != OWN_IFU);
  assign clint_req.write = 1'b0;
  assign clint_req.addr  = lsu_araddr_i;
  assign clint_req.wdata = '0;
  assign clint_req.strb  = lsu_rstrb_i;

  // responses go back to the owner only
  assign ifu_rvalid_o = (sel == OWN_IFU) && axi_req.done;
  assign ifu_rdata_o  = (sel == OWN_IFU) ? axi_req.rdata : '0;
  assign lsu_rvalid_o = ((sel == OWN_LOAD) && axi_req.done) || clint_req.done;
  assign lsu_rdata_o  = clint_req.done    ? clint_req.rdata :
                        (sel == OWN_LOAD) ? axi_req.rdata : '0;
  assign lsu_wready_o = (sel == OWN_STORE) && axi_req.done;

  // error rides on the completion pulse
  assign bus_error_o = (axi_req.done && axi_req.err) || (clint_req.done && clint_req.err);

endmodule

`default_nettype wire

// File: axi_bridge/axi_master_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module axi_master_bridge import bus_pkg::*, axi_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  mem_req_if.target              req,
  // read address
  output logic [`ADDR_W-1:0]     m_axi_araddr,
  output logic [2:0]             m_axi_arsize,
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  // read data
  input  logic [`AXI_DATA_W-1:0] m_axi_rdata,
  input  logic [1:0]             m_axi_rresp,
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  // write address
  output logic [`ADDR_W-1:0]     m_axi_awaddr,
  output logic [2:0]             m_axi_awsize,
  output logic                   m_axi_awvalid,
  input  logic                   m_axi_awready,
  // write data
  output logic [`AXI_DATA_W-1:0] m_axi_wdata,
  output logic [`AXI_STRB_W-1:0] m_axi_wstrb,
  output logic                   m_axi_wlast,
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  // write response
  input  logic [1:0]             m_axi_bresp,
  input  logic                   m_axi_bvalid,
  output logic                   m_axi_bready
);

  logic               busy_q;
  logic               ar_pend_q;
  logic               aw_pend_q;
  logic               w_pend_q;
  logic               start;
  logic [1:0]         resp;
  access_size_t       acc_size;
  axi_size_t          axi_size;
  logic [3:0]         strb_lane;
  logic [`DATA_W-1:0] wdata_lane;
  logic [`DATA_W-1:0] rdata_half;

  // new transfer only when nothing is outstanding
  assign start = req.valid && !busy_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q    <= 1'b0;
      ar_pend_q <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end
    else
    begin
      if (start)
        busy_q <= 1'b1;
      else if (req.done)
        busy_q <= 1'b0;
      // a channel stays pending only if ready missed the first cycle
      ar_pend_q <= m_axi_arvalid && !m_axi_arready;
      aw_pend_q <= m_axi_awvalid && !m_axi_awready;
      w_pend_q  <= m_axi_wvalid && !m_axi_wready;
    end
  end

  // first cycle is combinational from the request
  assign m_axi_arvalid = (start && !req.write) || ar_pend_q;
  assign m_axi_awvalid = (start && req.write) || aw_pend_q;
  assign m_axi_wvalid  = (start && req.write) || w_pend_q;

  // size code from the requester strobe
  assign acc_size = size_from_strb(req.strb);
  always_comb
  begin
    case (acc_size)
      SIZE_BYTE: axi_size = AXI_SIZE_1B;
      SIZE_HALF: axi_size = AXI_SIZE_2B;
      default:   axi_size = AXI_SIZE_4B;
    endcase
  end

  assign m_axi_araddr = req.addr;
  assign m_axi_awaddr = req.addr;
  assign m_axi_arsize = axi_size;
  assign m_axi_awsize = axi_size;

  // write side, shift into the byte offset then pick the lane
  assign wdata_lane  = req.wdata << {req.addr[1:0], 3'b000};
  assign strb_lane   = req.strb << req.addr[1:0];
  assign m_axi_wdata = {wdata_lane, wdata_lane};
  assign m_axi_wstrb = req.addr[2] ? {strb_lane, 4'b0000} : {4'b0000, strb_lane};
  // single beat
  assign m_axi_wlast = 1'b1;

  // read side, lane by addr[2], zero-filled right shift
  assign rdata_half = req.addr[2] ? m_axi_rdata[63:32] : m_axi_rdata[31:0];
  assign req.rdata  = rdata_half >> {req.addr[1:0], 3'b000};

  // completion on the response matching the transfer kind
  assign req.done = busy_q && (req.write ? m_axi_bvalid : m_axi_rvalid);
  assign resp     = req.write ? m_axi_bresp : m_axi_rresp;
  assign req.err  = req.done && (axi_resp_t'(resp) != AXI_RESP_OKAY);

  // responses are always accepted
  assign m_axi_rready = 1'b1;
  assign m_axi_bready = 1'b1;

endmodule

`default_nettype wire

// File: source/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module clint_timer (
  input  logic      clk,
  input  logic      rst,
  mem_req_if.target req
);

  logic [63:0]        mtime_q;
  logic               valid_q;
  logic               done_q;
  logic [`DATA_W-1:0] rdata_q;
  logic               take;

  // answer once per valid level
  assign take = req.valid && !valid_q;

  // free-running, zero right after reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      valid_q <= req.valid;
      done_q  <= take;
    end
  end

  // word sampled in the request cycle, addr[2] picks the half
  always_ff @(posedge clk)
  begin
    if (take)
      rdata_q <= req.addr[2] ? mtime_q[63:32] : mtime_q[31:0];
  end

  assign req.done  = done_q;
  assign req.rdata = rdata_q;
  // read-only timer, never fails
  assign req.err   = 1'b0;

endmodule

`default_nettype wire

// File: source/cpu_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module cpu_bus_top (
  input  logic                   clk,
  input  logic                   rst,
  // instruction fetch
  input  logic [`ADDR_W-1:0]     ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic [`DATA_W-1:0]     ifu_rdata_o,
  output logic                   ifu_rvalid_o,
  // lsu load
  input  logic [`ADDR_W-1:0]     lsu_araddr_i,
  input  logic                   lsu_arvalid_i,
  input  logic [3:0]             lsu_rstrb_i,
  output logic [`DATA_W-1:0]     lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  // lsu store
  input  logic [`ADDR_W-1:0]     lsu_awaddr_i,
  input  logic [`DATA_W-1:0]     lsu_wdata_i,
  input  logic [3:0]             lsu_wstrb_i,
  input  logic                   lsu_wvalid_i,
  output logic                   lsu_wready_o,
  output logic                   bus_error_o,
  // AXI4 master
  output logic [`ADDR_W-1:0]     m_axi_araddr,
  output logic [2:0]             m_axi_arsize,
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  input  logic [`AXI_DATA_W-1:0] m_axi_rdata,
  input  logic [1:0]             m_axi_rresp,
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  output logic [`ADDR_W-1:0]     m_axi_awaddr,
  output logic [2:0]             m_axi_awsize,
  output logic                   m_axi_awvalid,
  input  logic                   m_axi_awready,
  output logic [`AXI_DATA_W-1:0] m_axi_wdata,
  output logic [`AXI_STRB_W-1:0] m_axi_wstrb,
  output logic                   m_axi_wlast,
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  input  logic [1:0]             m_axi_bresp,
  input  logic                   m_axi_bvalid,
  output logic                   m_axi_bready
);

  // arbiter to bridge, arbiter to timer
  mem_req_if axi_req_bus ();
  mem_req_if clint_req_bus ();

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_wready_o  (lsu_wready_o),
    .bus_error_o   (bus_error_o),
    .axi_req       (axi_req_bus.requester),
    .clint_req     (clint_req_bus.requester)
  );

  axi_master_bridge u_bridge (
    .clk           (clk),
    .rst           (rst),
    .req           (axi_req_bus.target),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arsize  (m_axi_arsize),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rresp   (m_axi_rresp),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awsize  (m_axi_awsize),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready)
  );

  clint_timer u_clint (
    .clk (clk),
    .rst (rst),
    .req (clint_req_bus.target)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  // 10 ns period, first rising edge at 5 ns
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released on a falling edge after two rising edges
  initial
  begin
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/bus_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bus_chk (
  input logic        clk,
  input logic        rst,
  input logic [31:0] m_axi_araddr,
  input logic [2:0]  m_axi_arsize,
  input logic        m_axi_arvalid,
  input logic        m_axi_arready,
  input logic        ifu_arvalid_i,
  input logic        ifu_rvalid_o,
  input logic        lsu_arvalid_i,
  input logic        lsu_rvalid_o,
  input logic        lsu_wvalid_i,
  input logic        lsu_wready_o
);

  // arvalid and its payload stay put until the handshake
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    (m_axi_arvalid && !m_axi_arready) |=>
      (m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arsize)))
    else $error("arvalid or its payload changed before arready");

  // completion only for a live request
  ifu_pulse: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o |-> ifu_arvalid_i)
    else $error("fetch response without a fetch request");

  lsu_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o |-> lsu_arvalid_i)
    else $error("load response without a load request");

  store_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_wready_o |-> lsu_wvalid_i)
    else $error("store response without a store request");

  // read pulses never overlap
  one_read: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_o && lsu_rvalid_o))
    else $error("fetch and load responses in the same cycle");

endmodule

bind cpu_bus_top bus_chk u_chk (
  .clk           (clk),
  .rst           (rst),
  .m_axi_araddr  (m_axi_araddr),
  .m_axi_arsize  (m_axi_arsize),
  .m_axi_arvalid (m_axi_arvalid),
  .m_axi_arready (m_axi_arready),
  .ifu_arvalid_i (ifu_arvalid_i),
  .ifu_rvalid_o  (ifu_rvalid_o),
  .lsu_arvalid_i (lsu_arvalid_i),
  .lsu_rvalid_o  (lsu_rvalid_o),
  .lsu_wvalid_i  (lsu_wvalid_i),
  .lsu_wready_o  (lsu_wready_o)
);

`default_nettype wire

// File: tb/bus_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_monitor (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] ifu_araddr_i,
  input  logic        ifu_arvalid_i,
  input  logic [31:0] ifu_rdata_o,
  input  logic        ifu_rvalid_o,
  input  logic [31:0] lsu_araddr_i,
  input  logic        lsu_arvalid_i,
  input  logic [3:0]  lsu_rstrb_i,
  input  logic [31:0] lsu_rdata_o,
  input  logic        lsu_rvalid_o,
  input  logic [31:0] lsu_awaddr_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic [3:0]  lsu_wstrb_i,
  input  logic        lsu_wvalid_i,
  input  logic        lsu_wready_o,
  input  logic        bus_error_o,
  input  logic [31:0] m_axi_araddr,
  input  logic [2:0]  m_axi_arsize,
  input  logic        m_axi_arvalid,
  input  logic        m_axi_rready,
  input  logic [31:0] m_axi_awaddr,
  input  logic [2:0]  m_axi_awsize,
  input  logic        m_axi_awvalid,
  input  logic [63:0] m_axi_wdata,
  input  logic [7:0]  m_axi_wstrb,
  input  logic        m_axi_wlast,
  input  logic        m_axi_wvalid,
  input  logic        m_axi_bready,
  input  logic        inject_err_i,
  input  logic        test_end_i,
  input  logic [2:0]  test_id_i,
  input  logic        all_done_i,
  output int          err_count_o
);

  // byte model of the 4 KiB slave window
  logic [7:0]  model [0:4095];
  // mirrors mtime and is zero in the first cycle after reset
  logic [63:0] cyc;
  logic [63:0] ifu_start;
  logic [63:0] lsu_start;
  logic        ifu_prev;
  logic        lsu_prev;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;

  assign err_count_o = errors;

  // same fill as the slave memory with every address bit in it
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  initial
  begin
    for (int a = 0; a < 4096; a++)
      model[a] = fill_byte(12'(a));
  end

  function automatic logic [31:0] model_word(input logic [31:0] a);
    logic [31:0] w;
    for (int i = 0; i < 4; i++)
      w[8*i +: 8] = model[{a[11:2], 2'(i)}];
    return w;
  endfunction

  function automatic logic is_rtc(input logic [31:0] a);
    return (a == `RTC_ADDR) || (a == `RTC_ADDR_HI);
  endfunction

  // strobe 1 gives a byte, 3 a half and the rest a word
  function automatic logic [2:0] exp_size(input logic [3:0] s);
    if (s == 4'h1)
      return 3'd0;
    else if (s == 4'h3)
      return 3'd1;
    return 3'd2;
  endfunction

  // strobe bits inside the word placed in the lane of addr[2]
  function automatic logic [7:0] store_strb(input logic [31:0] a, input logic [3:0] s);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < 4; i++)
      if (s[i] && (int'(a[1:0]) + i < 4))
        r[{a[2], 2'(int'(a[1:0]) + i)}] = 1'b1;
    return r;
  endfunction

  // data moved up by the byte offset and copied into both lanes
  function automatic logic [63:0] store_data(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] lane;
    lane = '0;
    for (int j = 0; j < 4; j++)
      if (j >= int'(a[1:0]))
        lane[8*j +: 8] = d[8*(j - int'(a[1:0])) +: 8];
    return {lane, lane};
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "fetch";
      3'd2:    return "load sizes";
      3'd3:    return "store and read back";
      3'd4:    return "fetch/load ordering";
      3'd5:    return "mtime";
      default: return "error response";
    endcase
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    test_checks++;
    if (got !== exp)
    begin
      errors++;
      test_errors++;
      $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    test_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  always @(posedge clk)
  begin
    logic done_any;
    logic exp_err;
    logic load_owns;
    if (rst)
    begin
      cyc <= '0;
      ifu_prev = 1'b0;
      lsu_prev = 1'b0;
    end
    else
    begin
      cyc <= cyc + 64'd1;
      // request start cycles for ordering and mtime
      if (ifu_arvalid_i && !ifu_prev)
        ifu_start = cyc;
      if (lsu_arvalid_i && !lsu_prev)
        lsu_start = cyc;
      ifu_prev = ifu_arvalid_i;
      lsu_prev = lsu_arvalid_i;

      // a load owns the bridge unless an earlier fetch already holds it
      load_owns = lsu_arvalid_i && !is_rtc(lsu_araddr_i) &&
                  !(ifu_arvalid_i && (ifu_start < lsu_start));

      // AXI request side
      if (m_axi_arvalid)
      begin
        compare("araddr", 64'(m_axi_araddr),
                64'(load_owns ? lsu_araddr_i : ifu_araddr_i));
        compare("arsize", 64'(m_axi_arsize),
                64'(load_owns ? exp_size(lsu_rstrb_i) : 3'd2));
        compare("rready", 64'(m_axi_rready), 64'd1);
      end
      if (m_axi_awvalid)
      begin
        if (!lsu_wvalid_i)
          report_failure("write address issued with no store pending");
        compare("awaddr", 64'(m_axi_awaddr), 64'(lsu_awaddr_i));
        compare("awsize", 64'(m_axi_awsize), 64'(exp_size(lsu_wstrb_i)));
        compare("bready", 64'(m_axi_bready), 64'd1);
      end
      if (m_axi_wvalid)
      begin
        compare("wstrb", 64'(m_axi_wstrb), 64'(store_strb(lsu_awaddr_i, lsu_wstrb_i)));
        compare("wdata", m_axi_wdata, store_data(lsu_awaddr_i, lsu_wdata_i));
        compare("wlast", 64'(m_axi_wlast), 64'd1);
      end

      // fetch completion
      if (ifu_rvalid_o)
      begin
        if (lsu_arvalid_i && !is_rtc(lsu_araddr_i) && lsu_start <= ifu_start)
          report_failure("fetch completed ahead of a load raised no later than it");
        if (!inject_err_i)
          compare("fetch data", 64'(ifu_rdata_o), 64'(model_word(ifu_araddr_i)));
      end

      // load completion from the timer or AXI
      if (lsu_rvalid_o)
      begin
        if (is_rtc(lsu_araddr_i))
        begin
          compare("mtime latency", cyc, lsu_start + 64'd1);
          compare("mtime word", 64'(lsu_rdata_o),
                  64'(lsu_araddr_i[2] ? lsu_start[63:32] : lsu_start[31:0]));
        end
        else
        begin
          if (ifu_arvalid_i && ifu_start < lsu_start)
            report_failure("load completed while an earlier fetch was still waiting");
          if (!inject_err_i)
            compare("load data", 64'(lsu_rdata_o),
                    64'(model_word(lsu_araddr_i) >> (8 * lsu_araddr_i[1:0])));
        end
      end

      // a failed store leaves memory alone
      if (lsu_wready_o && !inject_err_i)
        for (int i = 0; i < 4; i++)
          if (lsu_wstrb_i[i] && (int'(lsu_awaddr_i[1:0]) + i < 4))
            model[lsu_awaddr_i[11:0] + 12'(i)] = lsu_wdata_i[8*i +: 8];

      // error pulse only with an AXI completion under injection
      done_any = ifu_rvalid_o || lsu_wready_o || (lsu_rvalid_o && !is_rtc(lsu_araddr_i));
      exp_err  = inject_err_i && done_any;
      if (done_any || lsu_rvalid_o || bus_error_o)
        compare("bus_error_o", 64'(bus_error_o), 64'(exp_err));

      if (test_end_i)
      begin
        $display("test %0d %s: %s, %0d checks, %0d errors", test_id_i,
                 test_name(test_id_i), (test_errors == 0) ? "ok" : "failed",
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
      if (all_done_i)
        $display("total: %0d checks, %0d errors", checks, errors);
    end
  end

endmodule

`default_nettype wire

// File: tb/bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_tb;

  // 200 transactions of at most 12 cycles plus slack
  localparam int TIMEOUT_CYCLES = 200 * 12 + 100;

  logic        clk;
  logic        rst;
  logic [31:0] ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic [31:0] lsu_araddr_i;
  logic        lsu_arvalid_i;
  logic [3:0]  lsu_rstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i;
  logic [31:0] lsu_wdata_i;
  logic [3:0]  lsu_wstrb_i;
  logic        lsu_wvalid_i;
  logic        lsu_wready_o;
  logic        bus_error_o;
  logic [31:0] m_axi_araddr;
  logic [2:0]  m_axi_arsize;
  logic        m_axi_arvalid;
  logic        m_axi_arready;
  logic [63:0] m_axi_rdata;
  logic [1:0]  m_axi_rresp;
  logic        m_axi_rvalid;
  logic        m_axi_rready;
  logic [31:0] m_axi_awaddr;
  logic [2:0]  m_axi_awsize;
  logic        m_axi_awvalid;
  logic        m_axi_awready;
  logic [63:0] m_axi_wdata;
  logic [7:0]  m_axi_wstrb;
  logic        m_axi_wlast;
  logic        m_axi_wvalid;
  logic        m_axi_wready;
  logic [1:0]  m_axi_bresp;
  logic        m_axi_bvalid;
  logic        m_axi_bready;

  logic        inject_err;
  logic        test_end;
  logic [2:0]  test_id;
  logic        all_done;
  int          err_count;
  int          cycles = 0;
  // slave memory of 512 words of 64 bits
  logic [63:0] mem [0:511];

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  cpu_bus_top DUT (.*);

  bus_monitor u_monitor (
    .*,
    .inject_err_i (inject_err),
    .test_end_i   (test_end),
    .test_id_i    (test_id),
    .all_done_i   (all_done),
    .err_count_o  (err_count)
  );

  // fill depends on the full byte address
  function automatic logic [7:0] pattern_byte(input logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic [31:0] rand_word();
    return 32'h8000_0000 | ($urandom & 32'h0000_0ffc);
  endfunction

  // AXI slave serving one transfer at a time with random 0..3 cycle delays
  initial
  begin
    logic [31:0] a;
    logic [63:0] wd;
    logic [7:0]  ws;
    int          da;
    int          dw;
    for (int i = 0; i < 4096; i++)
      mem[i / 8][8*(i % 8) +: 8] = pattern_byte(12'(i));
    m_axi_arready = 1'b0;
    m_axi_rdata   = '0;
    m_axi_rresp   = 2'b00;
    m_axi_rvalid  = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bresp   = 2'b00;
    m_axi_bvalid  = 1'b0;
    forever
    begin
      @(posedge clk);
      if (!rst && m_axi_arvalid)
      begin
        a = m_axi_araddr;
        repeat ($urandom % 4) @(posedge clk);
        @(negedge clk);
        m_axi_arready = 1'b1;
        @(negedge clk);
        m_axi_arready = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
        m_axi_rdata  = mem[a[11:3]];
        m_axi_rresp  = inject_err ? 2'b10 : 2'b00;
        m_axi_rvalid = 1'b1;
        @(negedge clk);
        m_axi_rvalid = 1'b0;
      end
      else if (!rst && m_axi_awvalid)
      begin
        a  = m_axi_awaddr;
        wd = m_axi_wdata;
        ws = m_axi_wstrb;
        da = int'($urandom % 4);
        dw = int'($urandom % 4);
        // aw and w handshake on their own cycles
        for (int c = 0; c < 4; c++)
        begin
          @(negedge clk);
          m_axi_awready = (c == da);
          m_axi_wready  = (c == dw);
        end
        @(negedge clk);
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        if (!inject_err)
          for (int b = 0; b < 8; b++)
            if (ws[b])
              mem[a[11:3]][8*b +: 8] = wd[8*b +: 8];
        repeat ($urandom % 4) @(negedge clk);
        m_axi_bresp  = inject_err ? 2'b10 : 2'b00;
        m_axi_bvalid = 1'b1;
        @(negedge clk);
        m_axi_bvalid = 1'b0;
      end
    end
  end

  task automatic fetch(input logic [31:0] a);
    @(negedge clk);
    ifu_araddr_i  = a;
    ifu_arvalid_i = 1'b1;
    @(posedge clk);
    while (!ifu_rvalid_o)
      @(posedge clk);
    @(negedge clk);
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic load(input logic [31:0] a, input logic [3:0] s);
    @(negedge clk);
    lsu_araddr_i  = a;
    lsu_rstrb_i   = s;
    lsu_arvalid_i = 1'b1;
    @(posedge clk);
    while (!lsu_rvalid_o)
      @(posedge clk);
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    @(negedge clk);
    lsu_awaddr_i = a;
    lsu_wdata_i  = d;
    lsu_wstrb_i  = s;
    lsu_wvalid_i = 1'b1;
    @(posedge clk);
    while (!lsu_wready_o)
      @(posedge clk);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
  endtask

  // mid set raises the load one cycle into the fetch
  task automatic fetch_with_load(input logic [31:0] fa, input logic [31:0] la, input logic mid);
    logic f_seen;
    logic l_seen;
    f_seen = 1'b0;
    l_seen = 1'b0;
    @(negedge clk);
    ifu_araddr_i  = fa;
    ifu_arvalid_i = 1'b1;
    if (mid)
      @(negedge clk);
    lsu_araddr_i  = la;
    lsu_rstrb_i   = 4'hf;
    lsu_arvalid_i = 1'b1;
    while (!(f_seen && l_seen))
    begin
      @(posedge clk);
      f_seen = f_seen || ifu_rvalid_o;
      l_seen = l_seen || lsu_rvalid_o;
      @(negedge clk);
      if (f_seen)
        ifu_arvalid_i = 1'b0;
      if (l_seen)
        lsu_arvalid_i = 1'b0;
    end
  endtask

  task automatic finish_test(input int id);
    @(negedge clk);
    test_id  = 3'(id);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial
  begin
    logic [3:0]  sizes [3];
    logic [31:0] a;
    logic [1:0]  off;
    int          k;
    sizes         = '{4'h1, 4'h3, 4'hf};
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rstrb_i   = 4'hf;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = 4'hf;
    lsu_wvalid_i  = 1'b0;
    inject_err    = 1'b0;
    test_end      = 1'b0;
    test_id       = 3'd0;
    all_done      = 1'b0;
    void'($urandom(66));
    @(negedge clk);
    while (rst)
      @(negedge clk);

    for (int i = 0; i < 40; i++)
      fetch(rand_word());
    finish_test(1);

    // every size at every offset
    for (int w = 0; w < 4; w++)
    begin
      a = rand_word();
      for (int s = 0; s < 3; s++)
        for (int o = 0; o < 4; o++)
          load(a | 32'(o), sizes[s]);
    end
    finish_test(2);

    for (int i = 0; i < 30; i++)
    begin
      k   = int'($urandom % 3);
      off = (k == 0) ? 2'($urandom % 4) : (k == 1) ? 2'(($urandom % 2) * 2) : 2'd0;
      a   = rand_word();
      store(a | {30'd0, off}, $urandom, sizes[k]);
      load(a, 4'hf);
    end
    finish_test(3);

    for (int i = 0; i < 8; i++)
      fetch_with_load(rand_word(), rand_word(), i[0]);
    finish_test(4);

    for (int i = 0; i < 8; i++)
      load(i[0] ? `RTC_ADDR_HI : `RTC_ADDR, 4'hf);
    finish_test(5);

    inject_err = 1'b1;
    load(rand_word(), 4'hf);
    store(rand_word(), $urandom, 4'hf);
    inject_err = 1'b0;
    load(rand_word(), 4'hf);
    store(rand_word(), $urandom, 4'hf);
    finish_test(6);

    @(negedge clk);
    all_done = 1'b1;
    @(negedge clk);
    all_done = 1'b0;
    if (err_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // run limit
  always @(posedge clk)
  begin
    if (rst)
      cycles <= 0;
    else
    begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/bus_pkg.sv
common/axi_pkg.sv
common/mem_req_if.sv
source/bus_arbiter.sv
axi_bridge/axi_master_bridge.sv
source/clint_timer.sv
source/cpu_bus_top.sv
tb/tb_clock.sv
tb/bus_chk.sv
tb/bus_monitor.sv
tb/bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bus testbench with Verilator
verilator --binary --timing --assert --top-module bus_tb -f filelist.f -o bus_sim \
  && ./obj_dir/bus_sim | tee /dev/stderr | grep -q ">>> PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
